// File: common/streamer_pkg.sv
// ====================
// Streamer package
// Widths, buffer depths, channel ids and bus structs
// shared by the load/store streamer blocks
// ====================

package streamer_pkg;

  // Word and address widths
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned LEN_W  = 16;

  // Three load channels plus one store channel on the arbiter
  localparam int unsigned NUM_SOURCES = 3;
  localparam int unsigned NUM_PORTS   = 4;

  // Load buffer depth doubles as the read credit limit
  localparam int unsigned LOAD_FIFO_DEPTH  = 4;
  localparam int unsigned STORE_FIFO_DEPTH = 2;

  // Channel ids, also used as arbiter port indices
  localparam int unsigned X_ID = 0;
  localparam int unsigned W_ID = 1;
  localparam int unsigned Y_ID = 2;
  localparam int unsigned Z_ID = 3;

  // Memory request, wen high means read
  typedef struct packed {
    logic                  req;
    logic                  wen;
    logic [ADDR_W-1:0]     add;
    logic [DATA_W-1:0]     data;
    logic [DATA_W/8-1:0]   be;
  } mem_req_t;

  // Memory answer, r_valid one cycle after a granted read
  typedef struct packed {
    logic              gnt;
    logic              r_valid;
    logic [DATA_W-1:0] r_data;
  } mem_rsp_t;

  // Forward half of a stream, ready travels separately
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
  } stream_t;

  // Per stream setup, stride is a byte step
  typedef struct packed {
    logic [ADDR_W-1:0] base_addr;
    logic [LEN_W-1:0]  length;
    logic [ADDR_W-1:0] stride;
  } stream_ctrl_t;

  typedef struct packed {
    logic         start;
    stream_ctrl_t x;
    stream_ctrl_t w;
    stream_ctrl_t y;
    stream_ctrl_t z;
  } ctrl_t;

  // Sticky done bits, one per channel
  typedef struct packed {
    logic x_done;
    logic w_done;
    logic y_done;
    logic z_done;
  } flags_t;

endpackage

// File: verilog/stream_fifo.sv
`timescale 1ns/10ps
// ====================
// Stream FIFO
// Circular word buffer with occupancy count
// ====================

module stream_fifo #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             clear_i,
  input  logic                             push_i,
  input  logic [streamer_pkg::DATA_W-1:0]  data_i,
  output logic                             full_o,
  input  logic                             pop_i,
  output logic [streamer_pkg::DATA_W-1:0]  data_o,
  output logic                             empty_o,
  output logic [$clog2(DEPTH+1)-1:0]       count_o
);
  import streamer_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [DATA_W-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              do_push;
  logic              do_pop;

  // Refused pushes and empty pops are dropped here
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign count_o = count_q;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap at DEPTH, which need not be a power of two
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (!do_push && do_pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: load/stream_source.sv
`timescale 1ns/10ps
// ====================
// Load stream source
// Strided memory reads into a buffered valid/ready stream
// Reads in flight are bounded by the buffer depth
// ====================

module stream_source (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            clear_i,
  input  logic                            start_i,
  input  streamer_pkg::stream_ctrl_t      ctrl_i,
  output streamer_pkg::mem_req_t          mem_req_o,
  input  logic                            mem_gnt_i,
  input  logic                            mem_rvalid_i,
  input  logic [streamer_pkg::DATA_W-1:0] mem_rdata_i,
  output streamer_pkg::stream_t           stream_o,
  input  logic                            stream_ready_i,
  output logic                            done_o
);
  import streamer_pkg::*;

  localparam int unsigned CNT_W = $clog2(LOAD_FIFO_DEPTH + 1);

  // Latched setup and running address
  logic [LEN_W-1:0]  len_q;
  logic [ADDR_W-1:0] stride_q;
  logic [ADDR_W-1:0] addr_q;

  logic              active_q;
  logic              done_q;
  logic [LEN_W-1:0]  req_cnt_q;
  logic [LEN_W-1:0]  out_cnt_q;
  logic [CNT_W-1:0]  inflight_q;

  logic [CNT_W-1:0]  fifo_cnt;
  logic [CNT_W:0]    used;
  logic              fifo_empty;
  logic [DATA_W-1:0] fifo_data;
  logic              issue;
  logic              grant;
  logic              pop;

  // Slots taken = reads still on the way + words already buffered
  assign used  = inflight_q + fifo_cnt;
  assign issue = active_q && (req_cnt_q != len_q) && (used < LOAD_FIFO_DEPTH);
  assign grant = issue && mem_gnt_i;
  assign pop   = stream_o.valid && stream_ready_i;

  // Read request, fields stay put until granted
  always_comb begin
    mem_req_o     = '0;
    mem_req_o.req = issue;
    mem_req_o.wen = 1'b1;
    mem_req_o.add = addr_q;
    mem_req_o.be  = '1;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q   <= 1'b0;
      done_q     <= 1'b0;
      req_cnt_q  <= '0;
      out_cnt_q  <= '0;
      inflight_q <= '0;
    end else if (clear_i) begin
      active_q   <= 1'b0;
      done_q     <= 1'b0;
      req_cnt_q  <= '0;
      out_cnt_q  <= '0;
      inflight_q <= '0;
    end else begin
      if (start_i) begin
        // Zero length finishes at once
        active_q  <= (ctrl_i.length != '0);
        done_q    <= (ctrl_i.length == '0);
        req_cnt_q <= '0;
        out_cnt_q <= '0;
      end else begin
        if (grant) begin
          req_cnt_q <= req_cnt_q + 1'b1;
        end
        if (pop && active_q) begin
          out_cnt_q <= out_cnt_q + 1'b1;
          // Last word left on the stream
          if (out_cnt_q == len_q - 1'b1) begin
            active_q <= 1'b0;
            done_q   <= 1'b1;
          end
        end
      end
      // Grant adds a read in flight, its response moves it into the buffer
      if (grant && !mem_rvalid_i) begin
        inflight_q <= inflight_q + 1'b1;
      end else if (!grant && mem_rvalid_i) begin
        inflight_q <= inflight_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      len_q    <= ctrl_i.length;
      stride_q <= ctrl_i.stride;
      addr_q   <= ctrl_i.base_addr;
    end else if (grant) begin
      addr_q <= addr_q + stride_q;
    end
  end

  // Response buffer, credits keep it from overflowing
  stream_fifo #(
    .DEPTH ( LOAD_FIFO_DEPTH )
  ) i_resp_fifo (
    .clk_i    ( clk_i        ),
    .arst_n_i ( arst_n_i     ),
    .clear_i  ( clear_i      ),
    .push_i   ( mem_rvalid_i ),
    .data_i   ( mem_rdata_i  ),
    .full_o   (              ),
    .pop_i    ( pop          ),
    .data_o   ( fifo_data    ),
    .empty_o  ( fifo_empty   ),
    .count_o  ( fifo_cnt     )
  );

  assign stream_o.valid = !fifo_empty;
  assign stream_o.data  = fifo_data;
  assign done_o         = done_q;

endmodule

// File: store/stream_sink.sv
`timescale 1ns/10ps
// ====================
// Store stream sink
// Buffers the incoming stream and writes each word
// to strided memory addresses
// ====================

module stream_sink (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       clear_i,
  input  logic                       start_i,
  input  streamer_pkg::stream_ctrl_t ctrl_i,
  input  streamer_pkg::stream_t      stream_i,
  output logic                       stream_ready_o,
  output streamer_pkg::mem_req_t     mem_req_o,
  input  logic                       mem_gnt_i,
  output logic                       done_o
);
  import streamer_pkg::*;

  logic [LEN_W-1:0]  len_q;
  logic [ADDR_W-1:0] stride_q;
  logic [ADDR_W-1:0] addr_q;

  logic              active_q;
  logic              done_q;
  logic [LEN_W-1:0]  wr_cnt_q;

  logic              fifo_full;
  logic              fifo_empty;
  logic [DATA_W-1:0] fifo_data;
  logic              push;
  logic              issue;
  logic              grant;

  // Input side only stalls on a full buffer
  assign stream_ready_o = !fifo_full;
  assign push           = stream_i.valid && stream_ready_o;

  // Head word goes out as a write until granted
  assign issue = active_q && !fifo_empty && (wr_cnt_q != len_q);
  assign grant = issue && mem_gnt_i;

  always_comb begin
    mem_req_o      = '0;
    mem_req_o.req  = issue;
    mem_req_o.wen  = 1'b0;
    mem_req_o.add  = addr_q;
    mem_req_o.data = fifo_data;
    mem_req_o.be   = '1;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q <= 1'b0;
      done_q   <= 1'b0;
      wr_cnt_q <= '0;
    end else if (clear_i) begin
      active_q <= 1'b0;
      done_q   <= 1'b0;
      wr_cnt_q <= '0;
    end else if (start_i) begin
      active_q <= (ctrl_i.length != '0);
      done_q   <= (ctrl_i.length == '0);
      wr_cnt_q <= '0;
    end else if (grant) begin
      wr_cnt_q <= wr_cnt_q + 1'b1;
      // Write of the last word accepted by memory
      if (wr_cnt_q == len_q - 1'b1) begin
        active_q <= 1'b0;
        done_q   <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      len_q    <= ctrl_i.length;
      stride_q <= ctrl_i.stride;
      addr_q   <= ctrl_i.base_addr;
    end else if (grant) begin
      addr_q <= addr_q + stride_q;
    end
  end

  // Z input buffer, popped on each granted write
  stream_fifo #(
    .DEPTH ( STORE_FIFO_DEPTH )
  ) i_store_fifo (
    .clk_i    ( clk_i         ),
    .arst_n_i ( arst_n_i      ),
    .clear_i  ( clear_i       ),
    .push_i   ( push          ),
    .data_i   ( stream_i.data ),
    .full_o   ( fifo_full     ),
    .pop_i    ( grant         ),
    .data_o   ( fifo_data     ),
    .empty_o  ( fifo_empty    ),
    .count_o  (               )
  );

  assign done_o = done_q;

endmodule

// File: verilog/ldst_mux.sv
`timescale 1ns/10ps
// ====================
// Load/store arbiter
// Round-robin merge of four requestors on one memory port
// Read responses routed back to their owner
// ====================

module ldst_mux (
  input  logic                                                 clk_i,
  input  logic                                                 arst_n_i,
  input  logic                                                 clear_i,
  input  streamer_pkg::mem_req_t [streamer_pkg::NUM_PORTS-1:0] req_i,
  output logic [streamer_pkg::NUM_PORTS-1:0]                   gnt_o,
  output logic [streamer_pkg::NUM_PORTS-1:0]                   rvalid_o,
  output logic [streamer_pkg::DATA_W-1:0]                      rdata_o,
  output streamer_pkg::mem_req_t                               mem_req_o,
  input  streamer_pkg::mem_rsp_t                               mem_rsp_i
);
  import streamer_pkg::*;

  localparam int unsigned IDX_W = $clog2(NUM_PORTS);

  logic [IDX_W-1:0] ptr_q;
  logic [IDX_W-1:0] cand;
  logic [IDX_W-1:0] win_idx;
  logic [IDX_W-1:0] next_ptr;
  logic             win_valid;
  logic             win_gnt;

  // Owner of the read granted last cycle
  logic             rd_valid_q;
  logic [IDX_W-1:0] rd_idx_q;

  // First requestor at or after the pointer wins
  always_comb begin
    win_valid = 1'b0;
    win_idx   = ptr_q;
    cand      = ptr_q;
    for (int unsigned off = 0; off < NUM_PORTS; off++) begin
      cand = IDX_W'((ptr_q + off) % NUM_PORTS);
      if (!win_valid && req_i[cand].req) begin
        win_valid = 1'b1;
        win_idx   = cand;
      end
    end
  end

  // Only the winner reaches memory
  assign mem_req_o = win_valid ? req_i[win_idx] : '0;
  assign win_gnt   = win_valid && mem_rsp_i.gnt;
  assign next_ptr  = (win_idx == IDX_W'(NUM_PORTS - 1)) ? '0 : win_idx + 1'b1;

  always_comb begin
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      gnt_o[p]    = win_gnt && (win_idx == IDX_W'(p));
      rvalid_o[p] = rd_valid_q && mem_rsp_i.r_valid && (rd_idx_q == IDX_W'(p));
    end
  end

  // Read data is shared, rvalid_o picks the owner
  assign rdata_o = mem_rsp_i.r_data;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q      <= '0;
      rd_valid_q <= 1'b0;
    end else if (clear_i) begin
      ptr_q      <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      if (win_gnt) begin
        ptr_q <= next_ptr;
      end
      rd_valid_q <= win_gnt && req_i[win_idx].wen;
    end
  end

  always_ff @(posedge clk_i) begin
    if (win_gnt) begin
      rd_idx_q <= win_idx;
    end
  end

endmodule

// File: verilog/redmule_streamer.sv
`timescale 1ns/10ps
// ====================
// Streamer top level
// X/W/Y load sources and Z store sink sharing one memory port
// ====================

module redmule_streamer (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   clear_i,
  input  streamer_pkg::ctrl_t    ctrl_i,
  output streamer_pkg::flags_t   flags_o,
  output streamer_pkg::stream_t  x_stream_o,
  output streamer_pkg::stream_t  w_stream_o,
  output streamer_pkg::stream_t  y_stream_o,
  input  logic                   x_ready_i,
  input  logic                   w_ready_i,
  input  logic                   y_ready_i,
  input  streamer_pkg::stream_t  z_stream_i,
  output logic                   z_ready_o,
  output streamer_pkg::mem_req_t mem_req_o,
  input  streamer_pkg::mem_rsp_t mem_rsp_i
);
  import streamer_pkg::*;

  // Per load channel vectors, indexed by channel id
  stream_ctrl_t [NUM_SOURCES-1:0] src_ctrl;
  stream_t      [NUM_SOURCES-1:0] src_stream;
  logic         [NUM_SOURCES-1:0] src_ready;
  logic         [NUM_SOURCES-1:0] src_done;
  logic                           z_done;

  // Arbiter ports, loads first then the store
  mem_req_t     [NUM_PORTS-1:0]   port_req;
  logic         [NUM_PORTS-1:0]   port_gnt;
  logic         [NUM_PORTS-1:0]   port_rvalid;
  logic         [DATA_W-1:0]      mem_rdata;

  assign src_ctrl[X_ID]  = ctrl_i.x;
  assign src_ctrl[W_ID]  = ctrl_i.w;
  assign src_ctrl[Y_ID]  = ctrl_i.y;
  assign src_ready[X_ID] = x_ready_i;
  assign src_ready[W_ID] = w_ready_i;
  assign src_ready[Y_ID] = y_ready_i;

  for (genvar i = 0; i < NUM_SOURCES; i++) begin : gen_sources
    stream_source i_source (
      .clk_i          ( clk_i          ),
      .arst_n_i       ( arst_n_i       ),
      .clear_i        ( clear_i        ),
      .start_i        ( ctrl_i.start   ),
      .ctrl_i         ( src_ctrl[i]    ),
      .mem_req_o      ( port_req[i]    ),
      .mem_gnt_i      ( port_gnt[i]    ),
      .mem_rvalid_i   ( port_rvalid[i] ),
      .mem_rdata_i    ( mem_rdata      ),
      .stream_o       ( src_stream[i]  ),
      .stream_ready_i ( src_ready[i]   ),
      .done_o         ( src_done[i]    )
    );
  end

  // Store channel, Z stream into memory
  stream_sink i_sink (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .clear_i        ( clear_i        ),
    .start_i        ( ctrl_i.start   ),
    .ctrl_i         ( ctrl_i.z       ),
    .stream_i       ( z_stream_i     ),
    .stream_ready_o ( z_ready_o      ),
    .mem_req_o      ( port_req[Z_ID] ),
    .mem_gnt_i      ( port_gnt[Z_ID] ),
    .done_o         ( z_done         )
  );

  ldst_mux i_ldst_mux (
    .clk_i     ( clk_i       ),
    .arst_n_i  ( arst_n_i    ),
    .clear_i   ( clear_i     ),
    .req_i     ( port_req    ),
    .gnt_o     ( port_gnt    ),
    .rvalid_o  ( port_rvalid ),
    .rdata_o   ( mem_rdata   ),
    .mem_req_o ( mem_req_o   ),
    .mem_rsp_i ( mem_rsp_i   )
  );

  assign x_stream_o     = src_stream[X_ID];
  assign w_stream_o     = src_stream[W_ID];
  assign y_stream_o     = src_stream[Y_ID];

  // Gather done bits
  assign flags_o.x_done = src_done[X_ID];
  assign flags_o.w_done = src_done[W_ID];
  assign flags_o.y_done = src_done[Y_ID];
  assign flags_o.z_done = z_done;

endmodule

// File: test/tb_tasks.svh
// ====================
// Streamer test tasks
// Value check, stream drive and collect,
// and the directed tests
// ====================

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
  if (got !== exp) begin
    error_count++;
    $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    $display("TESTS FAILED");
    $fatal(1, "Stopping at the first mismatch");
  end
endtask

function automatic stream_ctrl_t make_ctrl(input logic [31:0] base, input int len,
                                           input logic [31:0] stride);
  stream_ctrl_t c;
  c.base_addr = base;
  c.length    = LEN_W'(len);
  c.stride    = stride;
  return c;
endfunction

// Known Z words, index i of a store run
function automatic logic [31:0] store_word(input int i);
  return 32'hc0de_0000 ^ (32'(i) * 32'h0103_0507);
endfunction

// One cycle start pulse with the setup of all four channels
task automatic start_streams(input stream_ctrl_t x_c, input stream_ctrl_t w_c,
                             input stream_ctrl_t y_c, input stream_ctrl_t z_c);
  @(posedge clk);
  #1;
  ctrl.x     = x_c;
  ctrl.w     = w_c;
  ctrl.y     = y_c;
  ctrl.z     = z_c;
  ctrl.start = 1'b1;
  @(posedge clk);
  #1;
  ctrl.start = 1'b0;
endtask

task automatic wait_done(input int unsigned id);
  @(negedge clk);
  while (!done_bits[id]) begin
    @(negedge clk);
  end
endtask

// Takes len words from a load stream and checks each against the fill
task automatic collect_load(input int unsigned id, input logic [31:0] base,
                            input logic [31:0] stride, input int len,
                            input bit rand_ready);
  int     i;
  integer r;
  logic   rdy;
  i = 0;
  while (i < len) begin
    @(posedge clk);
    #1;
    r              = $random(seed);
    rdy            = rand_ready ? r[0] : 1'b1;
    load_ready[id] = rdy;
    @(negedge clk);
    if (load_stream[id].valid && rdy) begin
      check_value({load_name[id], ".data"}, load_stream[id].data,
                  init_word(base + 32'(i) * stride));
      i++;
    end
  end
  // Done one cycle after the last word, nothing left behind
  @(posedge clk);
  #1;
  load_ready[id] = 1'b0;
  @(negedge clk);
  check_value("flags_o done bit", 32'(done_bits[id]), 32'd1);
  check_value({load_name[id], ".valid"}, 32'(load_stream[id].valid), 32'd0);
endtask

task automatic drive_store(input int first, input int len);
  int i;
  @(posedge clk);
  #1;
  for (i = 0; i < len; i++) begin
    z_stream.valid = 1'b1;
    z_stream.data  = store_word(first + i);
    // Word moves on the edge after ready is seen high
    @(negedge clk);
    while (!z_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  end
  z_stream = '0;
endtask

task automatic check_store(input logic [31:0] base, input logic [31:0] stride,
                           input int first, input int len);
  int          i;
  logic [31:0] addr;
  wait_done(Z_ID);
  for (i = 0; i < len; i++) begin
    addr = base + 32'(i) * stride;
    check_value($sformatf("mem[%h]", addr), mem_words[addr[13:2]], store_word(first + i));
  end
endtask

task automatic test_reset_state();
  @(negedge clk);
  check_value("flags_o", 32'(flags), 32'd0);
  check_value("x_stream_o.valid", 32'(x_stream.valid), 32'd0);
  check_value("w_stream_o.valid", 32'(w_stream.valid), 32'd0);
  check_value("y_stream_o.valid", 32'(y_stream.valid), 32'd0);
  check_value("mem_req_o.req", 32'(mem_req.req), 32'd0);
  check_value("z_ready_o", 32'(z_ready), 32'd1);
endtask

task automatic test_single_load();
  stream_ctrl_t off;
  off = '0;
  start_streams(make_ctrl(32'h100, 8, 32'd4), off, off, off);
  collect_load(X_ID, 32'h100, 32'd4, 8, 1'b0);
endtask

// W ready toggles at random while X and Y drain freely
task automatic test_parallel_loads();
  stream_ctrl_t off;
  off = '0;
  start_streams(make_ctrl(32'h400, 12, 32'd4), make_ctrl(32'h800, 10, 32'd12),
                make_ctrl(32'h1000, 9, 32'd8), off);
  fork
    collect_load(X_ID, 32'h400, 32'd4, 12, 1'b0);
    collect_load(W_ID, 32'h800, 32'd12, 10, 1'b1);
    collect_load(Y_ID, 32'h1000, 32'd8, 9, 1'b0);
  join
endtask

task automatic test_store();
  stream_ctrl_t off;
  off = '0;
  start_streams(off, off, off, make_ctrl(32'h2000, 6, 32'd8));
  drive_store(0, 6);
  check_store(32'h2000, 32'd8, 0, 6);
endtask

task automatic test_load_store_clear();
  stream_ctrl_t off;
  off = '0;
  // Loads and the store use disjoint regions
  start_streams(make_ctrl(32'h0, 8, 32'd4), off, make_ctrl(32'h600, 6, 32'd16),
                make_ctrl(32'h3000, 8, 32'd4));
  fork
    collect_load(X_ID, 32'h0, 32'd4, 8, 1'b0);
    collect_load(Y_ID, 32'h600, 32'd16, 6, 1'b0);
    drive_store(16, 8);
  join
  check_store(32'h3000, 32'd4, 16, 8);
  // All loads fill their buffers with ready low, then clear hits mid transfer
  start_streams(make_ctrl(32'h100, 8, 32'd4), make_ctrl(32'h800, 8, 32'd12),
                make_ctrl(32'h1000, 8, 32'd8), off);
  @(negedge clk);
  while (!(x_stream.valid && w_stream.valid && y_stream.valid)) begin
    @(negedge clk);
  end
  @(posedge clk);
  #1;
  clear = 1'b1;
  @(posedge clk);
  #1;
  clear = 1'b0;
  @(negedge clk);
  check_value("flags_o", 32'(flags), 32'd0);
  check_value("x_stream_o.valid", 32'(x_stream.valid), 32'd0);
  check_value("w_stream_o.valid", 32'(w_stream.valid), 32'd0);
  check_value("y_stream_o.valid", 32'(y_stream.valid), 32'd0);
endtask

`endif

// File: test/tb_streamer.sv
`timescale 1ns/10ps
// ====================
// Streamer testbench
// Clock, reset, memory model, watchdog
// and the directed test sequence
// ====================

module tb_streamer;
  import streamer_pkg::*;

  localparam int unsigned MEM_WORDS      = 4096;
  // About ten times the ~90 test words, four cycles each
  localparam int          TIMEOUT_CYCLES = 4000;
  localparam logic [31:0] FILL_KEY       = 32'h5a5a_0f0f;

  logic     clk;
  logic     arst_n;
  logic     clear;
  ctrl_t    ctrl;
  flags_t   flags;
  stream_t  x_stream;
  stream_t  w_stream;
  stream_t  y_stream;
  stream_t  z_stream;
  logic     z_ready;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;

  // Load side seen by channel id
  stream_t              load_stream [NUM_SOURCES];
  logic                 load_ready  [NUM_SOURCES];
  string                load_name   [NUM_SOURCES] = '{"x_stream_o", "w_stream_o", "y_stream_o"};
  logic [NUM_PORTS-1:0] done_bits;

  logic [DATA_W-1:0] mem_words [MEM_WORDS];
  integer            seed = 32'h64b3_852d;
  int                error_count;
  int                cycles;

  assign load_stream[X_ID] = x_stream;
  assign load_stream[W_ID] = w_stream;
  assign load_stream[Y_ID] = y_stream;
  // Bit index matches the channel id
  assign done_bits = {flags.z_done, flags.y_done, flags.w_done, flags.x_done};

  // Initial memory content, every word differs from its neighbours
  function automatic logic [DATA_W-1:0] init_word(input logic [ADDR_W-1:0] addr);
    return addr ^ FILL_KEY;
  endfunction

  redmule_streamer dut_i (
    .clk_i      ( clk               ),
    .arst_n_i   ( arst_n            ),
    .clear_i    ( clear             ),
    .ctrl_i     ( ctrl              ),
    .flags_o    ( flags             ),
    .x_stream_o ( x_stream          ),
    .w_stream_o ( w_stream          ),
    .y_stream_o ( y_stream          ),
    .x_ready_i  ( load_ready[X_ID]  ),
    .w_ready_i  ( load_ready[W_ID]  ),
    .y_ready_i  ( load_ready[Y_ID]  ),
    .z_stream_i ( z_stream          ),
    .z_ready_o  ( z_ready           ),
    .mem_req_o  ( mem_req           ),
    .mem_rsp_i  ( mem_rsp           )
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Single port memory, read data one cycle after the grant
  initial begin : memory_model
    int          a;
    int          b;
    integer      r;
    logic        take_rd;
    logic        take_wr;
    logic [11:0] idx;
    logic [31:0] wdata;
    logic [3:0]  wbe;
    mem_rsp = '0;
    for (a = 0; a < MEM_WORDS; a++) begin
      mem_words[a] = init_word(32'(a) << 2);
    end
    forever begin
      // Request and grant are settled by mid cycle
      @(negedge clk);
      take_rd = mem_req.req && mem_rsp.gnt && mem_req.wen;
      take_wr = mem_req.req && mem_rsp.gnt && !mem_req.wen;
      idx     = mem_req.add[13:2];
      wdata   = mem_req.data;
      wbe     = mem_req.be;
      @(posedge clk);
      #1;
      mem_rsp.r_valid = take_rd;
      mem_rsp.r_data  = take_rd ? mem_words[idx] : '0;
      // Only enabled byte lanes are written
      for (b = 0; b < 4; b++) begin
        if (take_wr && wbe[b]) begin
          mem_words[idx][8*b +: 8] = wdata[8*b +: 8];
        end
      end
      r = $random(seed);
      // Grant on about three cycles in four
      mem_rsp.gnt = (r[1:0] != 2'b00);
    end
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped by the watchdog");
  end

  `include "tb_tasks.svh"

  initial begin : test_sequence
    arst_n           = 1'b0;
    clear            = 1'b0;
    ctrl             = '0;
    z_stream         = '0;
    load_ready[X_ID] = 1'b0;
    load_ready[W_ID] = 1'b0;
    load_ready[Y_ID] = 1'b0;
    error_count      = 0;
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;

    test_reset_state();
    test_single_load();
    test_parallel_loads();
    test_store();
    test_load_store_clear();

    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+test
common/streamer_pkg.sv
verilog/stream_fifo.sv
load/stream_source.sv
store/stream_sink.sv
verilog/ldst_mux.sv
verilog/redmule_streamer.sv
test/tb_streamer.sv

// File: Makefile
# Verilator build and run for the streamer testbench

VERILATOR ?= verilator
TOP       := tb_streamer
FILELIST  := list.f
VFLAGS    := --binary --timing -j 0 --top-module $(TOP)
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not from the simulator exit code
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
